/* filelist.f */
ecd_axi_pkg.sv
ecd_regs_pkg.sv
ecd_reg_file.sv
ecd_burst_requester.sv
ecd_stream_router.sv
ecd_buffer_monitor.sv
ecd_master_ctrl.sv
tb_ecd_master_ctrl.sv

/* Bender.yml */
package:
  name: ecd

sources:
  - files:
      - ecd_axi_pkg.sv
      - ecd_regs_pkg.sv
      - ecd_reg_file.sv
      - ecd_burst_requester.sv
      - ecd_stream_router.sv
      - ecd_buffer_monitor.sv
      - ecd_master_ctrl.sv
  - target: test
    files:
      - tb_ecd_master_ctrl.sv

/* tb_ecd_master_ctrl.sv */
`timescale 1ns/10ps

module tb_ecd_master_ctrl
    import ecd_axi_pkg::*;
    import ecd_regs_pkg::*;
();

    localparam int clk_period = 100;
    localparam int n_rows     = 16;
    localparam int n_blocks   = 3;
    localparam logic [63:0] base_addr = 64'h0000_0001_8000_0000;

    typedef enum {op_wr, op_rd, op_idle, op_run} op_e;

    // One table row with its stimulus and the expected answer
    typedef struct {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [1:0]  resp;
    } row_t;

    logic        clk = 1'b0;
    logic        resetn;
    reg_wr_req_t reg_wr;
    reg_rd_req_t reg_rd;
    logic [1:0]  wr_resp;
    reg_rd_rsp_t rd_rsp;
    ar_req_t     ar;
    logic        ar_ready;
    r_beat_t     r;
    logic        r_ready;
    axis_beat_t  tx0;
    axis_beat_t  tx1;
    logic        tx0_ready;
    logic        tx1_ready;
    logic        irq_eob;
    logic        preload_complete;

    row_t         rows [n_rows];
    integer       seed;
    logic [511:0] beat_data;

    // Read slave state and the reference model of the DUT
    int cyc;
    int pending;
    int beats;
    int lasts;
    int ar_count;
    int irq_seen;
    int pl_seen;
    int start_cyc = -100;
    int pause_model;
    bit ar_fire;
    bit r_fire;
    bit exp_sel;
    bit irq_pend;
    bit pl_pend;
    bit pl_armed;
    int errors;
    int checks;

    always #(clk_period / 2) clk = ~clk;

    ecd_master_ctrl #(
        .beats_per_burst (4)
    ) i_dut (
        .clk              (clk),
        .resetn           (resetn),
        .reg_wr           (reg_wr),
        .reg_rd           (reg_rd),
        .wr_resp          (wr_resp),
        .rd_rsp           (rd_rsp),
        .ar               (ar),
        .ar_ready         (ar_ready),
        .r                (r),
        .r_ready          (r_ready),
        .tx0              (tx0),
        .tx0_ready        (tx0_ready),
        .tx1              (tx1),
        .tx1_ready        (tx1_ready),
        .irq_eob          (irq_eob),
        .preload_complete (preload_complete)
    );

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_rd_rsp(input reg_rd_rsp_t got, input reg_rd_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: read data %h resp %0d, expected data %h resp %0d",
                     $time, got.data, got.resp, exp.data, exp.resp);
        end
    endtask

    task automatic check_wr_resp(input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: write resp %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_ar(input ar_req_t got, input ar_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: request addr %h len %0d size %0d burst %0d, expected %h",
                     $time, got.addr, got.len, got.size, got.burst, exp.addr);
        end
    endtask

    task automatic check_beat(input axis_beat_t got, input axis_beat_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: stream beat %0d valid %b data %h, expected %h",
                     $time, beats, got.valid, got.data, exp.data);
        end
    endtask

    task automatic check_pulse(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0t ns: %0d %s, expected %0d", $time, got, what, exp);
        end
    endtask

    // ==============================
    // Read slave and checkers
    // ==============================

    // Byte 0 of the host data ends up as byte 63 of the stream beat
    function automatic logic [511:0] reverse_bytes(input logic [511:0] d);
        logic [511:0] q;
        for (int i = 0; i < 64; i++) begin
            q[8*(63-i) +: 8] = d[8*i +: 8];
        end
        return q;
    endfunction

    task automatic draw_beat();
        for (int i = 0; i < 16; i++) begin
            beat_data[32*i +: 32] = $random(seed);
        end
    endtask

    // Runs just after the falling edge once all inputs are settled
    task automatic observe_cycle();
        axis_beat_t sel_beat;
        axis_beat_t idle_beat;
        logic       sel_ready;
        // Pulses predicted in the previous cycle have to show up now
        check_pulse("irq_eob", irq_eob, irq_pend);
        check_pulse("preload_complete", preload_complete, pl_pend);
        irq_seen += irq_eob;
        pl_seen  += preload_complete;
        irq_pend = 1'b0;
        pl_pend  = 1'b0;
        // The detector arms one cycle after the start pulse
        if (cyc == start_cyc + 2) begin
            pl_armed = 1'b1;
        end
        if (pl_armed && !tx0_ready) begin
            pl_pend  = 1'b1;
            pl_armed = 1'b0;
        end
        if (pause_model != 0) begin
            check_pulse("ar.valid while paused", ar.valid, 1'b0);
        end
        ar_fire = ar.valid && ar_ready;
        if (ar_fire) begin
            // Three blocks of 4 beats of 64 bytes, then back to the base
            check_ar(ar, '{valid: 1'b1, addr: base_addr + 64'd256 * (ar_count % n_blocks),
                           len: 8'd3, size: 3'd6, burst: 2'd1});
            ar_count++;
        end
        sel_ready = exp_sel ? tx1_ready : tx0_ready;
        r_fire    = r.valid && r_ready;
        if (r.valid) begin
            sel_beat  = exp_sel ? tx1 : tx0;
            idle_beat = exp_sel ? tx0 : tx1;
            check_pulse("r_ready", r_ready, sel_ready);
            check_pulse("unselected stream valid", idle_beat.valid, 1'b0);
            check_beat(sel_beat, '{valid: 1'b1, data: reverse_bytes(r.data)});
        end
        if (r_fire) begin
            exp_sel = !exp_sel;
            if (r.last) begin
                lasts++;
                irq_pend = (lasts % n_blocks) == 0;
            end
        end
        // Register writes seen this cycle take effect from the next one
        if (reg_wr.write && reg_wr.addr[6:2] == 5'd3) begin
            start_cyc = cyc;
        end
        if (reg_wr.write && reg_wr.addr[6:2] == 5'd4) begin
            pause_model = reg_wr.data;
        end else if (pause_model != 0) begin
            pause_model--;
        end
    endtask

    always @(negedge clk) begin
        cyc++;
        // Each accepted request queues 4 beats and each accepted beat pops one
        if (ar_fire) begin
            pending += 4;
        end
        if (r_fire) begin
            pending--;
            beats++;
            draw_beat();
        end
        // Scripted ready pattern so both streams and the AR channel stall now and then
        ar_ready  = (cyc % 4) != 1;
        tx0_ready = (cyc % 7) != 3;
        tx1_ready = (cyc % 5) != 2;
        r.valid   = pending > 0;
        r.last    = (beats % 4) == 3;
        r.data    = beat_data;
        #1;
        if (resetn) begin
            observe_cycle();
        end
    end

    // ==============================
    // Stimulus table
    // ==============================

    task automatic build_table();
        rows[0]  = '{op_wr, 32'h00, base_addr[63:32], 32'h0, resp_okay};
        rows[1]  = '{op_wr, 32'h04, base_addr[31:0], 32'h0, resp_okay};
        rows[2]  = '{op_wr, 32'h08, n_blocks, 32'h0, resp_okay};
        rows[3]  = '{op_rd, 32'h00, 32'h0, base_addr[63:32], resp_okay};
        rows[4]  = '{op_rd, 32'h04, 32'h0, base_addr[31:0], resp_okay};
        rows[5]  = '{op_rd, 32'h08, 32'h0, n_blocks, resp_okay};
        rows[6]  = '{op_wr, 32'h1c, 32'h5, 32'h0, resp_decerr};
        rows[7]  = '{op_rd, 32'h1c, 32'h0, 32'h0, resp_decerr};
        rows[8]  = '{op_rd, 32'h0c, 32'h0, 32'h0, resp_decerr};
        rows[9]  = '{op_wr, 32'h10, 32'd20, 32'h0, resp_okay};
        rows[10] = '{op_wr, 32'h0c, 32'h0, 32'h0, resp_okay};
        // Six cycles after the pause write the count has dropped by six
        rows[11] = '{op_idle, 32'h0, 32'd5, 32'h0, resp_okay};
        rows[12] = '{op_rd, 32'h10, 32'h0, 32'd14, resp_okay};
        rows[13] = '{op_idle, 32'h0, 32'd30, 32'h0, resp_okay};
        rows[14] = '{op_rd, 32'h10, 32'h0, 32'd0, resp_okay};
        // Four buffer passes of three blocks each
        rows[15] = '{op_run, 32'h0, 32'd12, 32'd4, resp_okay};
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] resp);
        reg_wr.write = 1'b1;
        reg_wr.addr  = addr;
        reg_wr.data  = data;
        @(negedge clk);
        reg_wr = '0;
        check_wr_resp(wr_resp, resp);
    endtask

    task automatic read_reg(input logic [31:0] addr, input reg_rd_rsp_t exp);
        reg_rd.read = 1'b1;
        reg_rd.addr = addr;
        @(negedge clk);
        reg_rd = '0;
        check_rd_rsp(rd_rsp, exp);
    endtask

    task automatic apply_row(input row_t row);
        case (row.op)
            op_wr:   write_reg(row.addr, row.data, row.resp);
            op_rd:   read_reg(row.addr, '{data: row.exp, resp: row.resp});
            op_idle: repeat (row.data) @(negedge clk);
            default: begin
                while (lasts < row.data) begin
                    @(negedge clk);
                end
                // Leave room for the last interrupt pulse
                repeat (2) @(negedge clk);
                check_count("irq_eob pulses", irq_seen, row.exp);
                check_count("preload_complete pulses", pl_seen, 1);
            end
        endcase
    endtask

    initial begin
        seed      = 32'hb4497d29;
        resetn    = 1'b0;
        reg_wr    = '0;
        reg_rd    = '0;
        ar_ready  = 1'b0;
        r         = '0;
        tx0_ready = 1'b0;
        tx1_ready = 1'b0;
        draw_beat();
        build_table();
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
            $display("test %0d %s finished, %0d errors so far", i, rows[i].op.name(), errors);
        end
        $display("%0d tests, %0d checks, %0d errors", n_rows, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Each table row gets a budget of 200 clock cycles
    initial begin
        #(n_rows * 200 * clk_period);
        $display("timeout: the tests did not finish within %0d cycles", n_rows * 200);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* ecd_master_ctrl.sv */
`timescale 1ns/10ps

module ecd_master_ctrl import ecd_axi_pkg::*; import ecd_regs_pkg::*; #(
    parameter int unsigned beats_per_burst = 32
) (
    input  logic        clk,
    input  logic        resetn,

    // Host register port
    input  reg_wr_req_t reg_wr,
    input  reg_rd_req_t reg_rd,
    output logic [1:0]  wr_resp,
    output reg_rd_rsp_t rd_rsp,

    // AXI read-address channel
    output ar_req_t     ar,
    input  logic        ar_ready,

    // AXI read-data channel
    input  r_beat_t     r,
    output logic        r_ready,

    // Stream outputs
    output axis_beat_t  tx0,
    input  logic        tx0_ready,
    output axis_beat_t  tx1,
    input  logic        tx1_ready,

    // Status pulses
    output logic        irq_eob,
    output logic        preload_complete
);

    // ==============================
    // Internal wiring
    // ==============================

    dma_cfg_t cfg;
    logic     start;
    logic     pause;
    logic     busy;
    logic     block_done;

    // Software-visible registers and the start strobe
    ecd_reg_file i_reg_file (
        .clk     (clk),
        .resetn  (resetn),
        .reg_wr  (reg_wr),
        .reg_rd  (reg_rd),
        .wr_resp (wr_resp),
        .rd_rsp  (rd_rsp),
        .cfg     (cfg),
        .start   (start),
        .pause   (pause)
    );

    // One read burst per buffer block
    ecd_burst_requester #(
        .beats_per_burst (beats_per_burst)
    ) i_requester (
        .clk      (clk),
        .resetn   (resetn),
        .cfg      (cfg),
        .start    (start),
        .pause    (pause),
        .ar_ready (ar_ready),
        .ar       (ar),
        .busy     (busy)
    );

    // Returned beats go out alternately on the two streams
    ecd_stream_router i_router (
        .clk        (clk),
        .resetn     (resetn),
        .r          (r),
        .busy       (busy),
        .tx0_ready  (tx0_ready),
        .tx1_ready  (tx1_ready),
        .r_ready    (r_ready),
        .tx0        (tx0),
        .tx1        (tx1),
        .block_done (block_done)
    );

    // Buffer pass interrupt and preload pulse
    ecd_buffer_monitor i_monitor (
        .clk              (clk),
        .resetn           (resetn),
        .cfg              (cfg),
        .start            (start),
        .block_done       (block_done),
        .tx0_ready        (tx0_ready),
        .irq_eob          (irq_eob),
        .preload_complete (preload_complete)
    );

endmodule

/* ecd_buffer_monitor.sv */
`timescale 1ns/10ps

module ecd_buffer_monitor import ecd_regs_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  dma_cfg_t cfg,
    input  logic     start,
    input  logic     block_done,
    input  logic     tx0_ready,
    output logic     irq_eob,
    output logic     preload_complete
);

    // Blocks still to arrive before the buffer pass is complete
    logic [31:0] blocks_to_read;

    // Set by start and cleared once the first stall on tx0 is reported
    logic        armed;

    // ==============================
    // End of buffer interrupt
    // ==============================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            blocks_to_read <= 32'd0;
            irq_eob        <= 1'b0;
        end else begin
            // The interrupt is a one-cycle pulse
            irq_eob <= 1'b0;

            if (start) begin
                blocks_to_read <= cfg.blocks;
            end else if (block_done) begin
                if (blocks_to_read <= 32'd1) begin
                    // Whole buffer has been received so start counting the next pass
                    blocks_to_read <= cfg.blocks;
                    irq_eob        <= 1'b1;
                end else begin
                    blocks_to_read <= blocks_to_read - 32'd1;
                end
            end
        end
    end

    // ==============================
    // Preload detector
    // ==============================

    // tx0 going not-ready means its downstream FIFO has filled up
    always_ff @(posedge clk) begin
        if (!resetn) begin
            armed            <= 1'b0;
            preload_complete <= 1'b0;
        end else begin
            preload_complete <= 1'b0;

            if (!armed) begin
                if (start) begin
                    armed <= 1'b1;
                end
            end else if (!tx0_ready) begin
                preload_complete <= 1'b1;
                armed            <= 1'b0;
            end
        end
    end

endmodule

/* ecd_stream_router.sv */
`timescale 1ns/10ps

module ecd_stream_router import ecd_axi_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  r_beat_t    r,
    input  logic       busy,
    input  logic       tx0_ready,
    input  logic       tx1_ready,
    output logic       r_ready,
    output axis_beat_t tx0,
    output axis_beat_t tx1,
    output logic       block_done
);

    // Low steers the next beat to tx0
    logic                      sel;
    logic                      sel_ready;
    logic [axi_data_width-1:0] swapped;

    // The host delivers the buffer in little-endian byte order
    always_comb begin
        for (int i = 0; i < axi_data_bytes; i++) begin
            swapped[8*i +: 8] = r.data[8*(axi_data_bytes-1-i) +: 8];
        end
    end

    assign sel_ready = sel ? tx1_ready : tx0_ready;

    // Before the first start stray read data is simply swallowed
    assign r_ready = sel_ready | ~busy;

    // Both outputs share the data and only the selected one is valid
    always_comb begin
        tx0.data  = swapped;
        tx1.data  = swapped;
        tx0.valid = r.valid & busy & ~sel;
        tx1.valid = r.valid & busy & sel;
    end

    // Each accepted last beat closes one block
    assign block_done = busy & r.valid & r_ready & r.last;

    // ==============================
    // Channel alternation
    // ==============================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sel <= 1'b0;
        end else if (r.valid && sel_ready) begin
            sel <= ~sel;
        end
    end

endmodule

/* ecd_burst_requester.sv */
`timescale 1ns/10ps

module ecd_burst_requester import ecd_axi_pkg::*; import ecd_regs_pkg::*; #(
    parameter int unsigned beats_per_burst = 32
) (
    input  logic     clk,
    input  logic     resetn,
    input  dma_cfg_t cfg,
    input  logic     start,
    input  logic     pause,
    input  logic     ar_ready,
    output ar_req_t  ar,
    output logic     busy
);

    // Address step between consecutive blocks
    localparam logic [axi_addr_width-1:0] bytes_per_burst = axi_data_bytes * beats_per_burst;

    // State encoding
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_load  = 2'd1;
    localparam logic [1:0] st_issue = 2'd2;

    logic [1:0]                state;
    logic                      ar_valid;
    logic [axi_addr_width-1:0] ar_addr;

    // Blocks of this pass still to request, the current one included
    logic [31:0]               blocks_left;

    // Once started the requester never returns to idle
    assign busy = (state != st_idle);

    // The burst shape is fixed so only valid and addr come from registers
    always_comb begin
        ar.valid = ar_valid;
        ar.addr  = ar_addr;
        ar.len   = 8'(beats_per_burst - 1);
        ar.size  = 3'(axi_size_code);
        ar.burst = 2'(burst_incr);
    end

    // ==============================
    // Request FSM
    // ==============================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= st_idle;
            ar_valid    <= 1'b0;
            ar_addr     <= '0;
            blocks_left <= 32'd0;
        end else begin
            case (state)
                // Wait for software to kick off the transfer
                st_idle: begin
                    if (start) begin
                        state <= st_load;
                    end
                end

                // Begin a new pass at the base of the buffer
                st_load: begin
                    if (!pause) begin
                        ar_addr     <= cfg.base.flat;
                        blocks_left <= cfg.blocks;
                        ar_valid    <= 1'b1;
                        state       <= st_issue;
                    end
                end

                st_issue: begin
                    if (ar_valid) begin
                        if (ar_ready) begin
                            if (blocks_left <= 32'd1) begin
                                // Last block of the pass was accepted so wrap to the base
                                ar_valid <= 1'b0;
                                state    <= st_load;
                            end else begin
                                // Advance to the next block and hold it back while paused
                                ar_addr     <= ar_addr + bytes_per_burst;
                                blocks_left <= blocks_left - 32'd1;
                                ar_valid    <= !pause;
                            end
                        end
                    end else if (!pause) begin
                        // Pause is over so offer the already stepped address
                        ar_valid <= 1'b1;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* ecd_reg_file.sv */
`timescale 1ns/10ps

module ecd_reg_file import ecd_regs_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  reg_wr_req_t reg_wr,
    input  reg_rd_req_t reg_rd,
    output logic [1:0]  wr_resp,
    output reg_rd_rsp_t rd_rsp,
    output dma_cfg_t    cfg,
    output logic        start,
    output logic        pause
);

    // Register indices taken from the byte addresses
    logic [4:0]  wr_idx;
    logic [4:0]  rd_idx;

    // Remaining pause cycles
    logic [31:0] pause_count;

    assign wr_idx = reg_wr.addr[6:2];
    assign rd_idx = reg_rd.addr[6:2];

    // New requests are held off for as long as the countdown runs
    assign pause = (pause_count != 32'd0);

    // ==============================
    // Write side
    // ==============================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cfg         <= '0;
            pause_count <= 32'd0;
            start       <= 1'b0;
            wr_resp     <= resp_okay;
        end else begin
            // Start is a single-cycle strobe
            start <= 1'b0;

            // The pause register always runs down toward zero
            if (pause) begin
                pause_count <= pause_count - 32'd1;
            end

            // A host write overrides the countdown in the same cycle
            if (reg_wr.write) begin
                wr_resp <= resp_okay;
                case (wr_idx)
                    reg_buffh:     cfg.base.half.hi <= reg_wr.data;
                    reg_buffl:     cfg.base.half.lo <= reg_wr.data;
                    reg_buff_size: cfg.blocks       <= reg_wr.data;
                    reg_pause:     pause_count      <= reg_wr.data;
                    // The data of a start write carries no meaning
                    reg_start:     start            <= 1'b1;
                    default:       wr_resp          <= resp_decerr;
                endcase
            end
        end
    end

    // ==============================
    // Read side
    // ==============================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_rsp <= '0;
        end else if (reg_rd.read) begin
            rd_rsp.resp <= resp_okay;
            case (rd_idx)
                reg_buffh:     rd_rsp.data <= cfg.base.half.hi;
                reg_buffl:     rd_rsp.data <= cfg.base.half.lo;
                reg_buff_size: rd_rsp.data <= cfg.blocks;
                // Software sees the live countdown value
                reg_pause:     rd_rsp.data <= pause_count;
                // Start is write-only so it falls through with the unmapped indices
                default: begin
                    rd_rsp.data <= 32'd0;
                    rd_rsp.resp <= resp_decerr;
                end
            endcase
        end
    end

endmodule

/* ecd_regs_pkg.sv */
package ecd_regs_pkg;

    // ==============================
    // Register map
    // ==============================

    // The index of a register is its byte address bits 6 to 2
    localparam logic [4:0] reg_buffh     = 5'd0;
    localparam logic [4:0] reg_buffl     = 5'd1;
    localparam logic [4:0] reg_buff_size = 5'd2;
    localparam logic [4:0] reg_start     = 5'd3;
    localparam logic [4:0] reg_pause     = 5'd4;

    // Response codes returned on the register port
    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_decerr = 2'd3;

    // ==============================
    // Register port
    // ==============================

    // Write strobe with its byte address and data
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] data;
    } reg_wr_req_t;

    // Read strobe with its byte address
    typedef struct packed {
        logic        read;
        logic [31:0] addr;
    } reg_rd_req_t;

    // Registered answer to a read strobe
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } reg_rd_rsp_t;

    // ==============================
    // Transfer configuration
    // ==============================

    // Software writes the buffer base as two halves
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } buf_addr_halves_t;

    // The requester reads the same word back as one flat address
    typedef union packed {
        buf_addr_halves_t half;
        logic [63:0]      flat;
    } buf_addr_u;

    // Everything the requester and monitor need to walk the buffer
    typedef struct packed {
        buf_addr_u   base;
        logic [31:0] blocks;
    } dma_cfg_t;

endpackage

/* ecd_axi_pkg.sv */
package ecd_axi_pkg;

    // ==============================
    // Bus geometry
    // ==============================

    // Width of one read beat on the AXI master port
    localparam int unsigned axi_data_width = 512;

    // Host addresses are full 64-bit PCIe addresses
    localparam int unsigned axi_addr_width = 64;

    // Bytes carried by one beat
    localparam int unsigned axi_data_bytes = axi_data_width / 8;

    // ARSIZE encodes log2 of the bytes per beat
    localparam int unsigned axi_size_code = $clog2(axi_data_bytes);

    // ARBURST code for an incrementing burst
    localparam int unsigned burst_incr = 1;

    // ==============================
    // Channel payloads
    // ==============================

    // One request on the read-address channel
    typedef struct packed {
        logic                      valid;
        logic [axi_addr_width-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
    } ar_req_t;

    // One beat returned on the read-data channel
    typedef struct packed {
        logic                      valid;
        logic                      last;
        logic [axi_data_width-1:0] data;
    } r_beat_t;

    // One beat offered on a stream output
    typedef struct packed {
        logic                      valid;
        logic [axi_data_width-1:0] data;
    } axis_beat_t;

endpackage
